/* design/isa_pkg.sv */
// ISA widths, instruction field positions and opcode values
package isa_pkg;

	localparam int XLEN  = 64;                    // Register and data width
	localparam int ILEN  = 32;                    // Instruction width
	localparam int OP_W  = 5;
	localparam int REG_W = 5;
	localparam int IMM_W = 12;                    // Raw literal, sign-extended

	// Field positions in the instruction word
	localparam int OP_LSB = 27;
	localparam int RD_LSB = 22;
	localparam int RS_LSB = 17;
	localparam int RT_LSB = 12;

	// ------------------------------------------------------------
	localparam logic [OP_W-1:0] OP_AND    = 5'h00;
	localparam logic [OP_W-1:0] OP_OR     = 5'h01;
	localparam logic [OP_W-1:0] OP_XOR    = 5'h02;
	localparam logic [OP_W-1:0] OP_NOT    = 5'h03;
	localparam logic [OP_W-1:0] OP_SHFTR  = 5'h04;  // Logical
	localparam logic [OP_W-1:0] OP_SHFTRI = 5'h05;  // Arithmetic
	localparam logic [OP_W-1:0] OP_SHFTL  = 5'h06;
	localparam logic [OP_W-1:0] OP_SHFTLI = 5'h07;
	localparam logic [OP_W-1:0] OP_BR     = 5'h08;
	localparam logic [OP_W-1:0] OP_BRR    = 5'h09;
	localparam logic [OP_W-1:0] OP_BRRI   = 5'h0A;
	localparam logic [OP_W-1:0] OP_BRNZ   = 5'h0B;
	localparam logic [OP_W-1:0] OP_BRGT   = 5'h0E;
	localparam logic [OP_W-1:0] OP_LOAD   = 5'h10;
	localparam logic [OP_W-1:0] OP_MOV    = 5'h11;
	localparam logic [OP_W-1:0] OP_MOVI   = 5'h12;
	localparam logic [OP_W-1:0] OP_STORE  = 5'h13;
	localparam logic [OP_W-1:0] OP_ADD    = 5'h18;
	localparam logic [OP_W-1:0] OP_ADDI   = 5'h19;
	localparam logic [OP_W-1:0] OP_SUB    = 5'h1A;
	localparam logic [OP_W-1:0] OP_SUBI   = 5'h1B;
	localparam logic [OP_W-1:0] OP_MUL    = 5'h1C;
	localparam logic [OP_W-1:0] OP_DIV    = 5'h1D;
	localparam logic [OP_W-1:0] OP_HALT   = 5'h1F;

endpackage

/* design/core_pkg.sv */
// Machine constants for memory size, reset PC and FSM state codes
package core_pkg;

	localparam int MEM_BYTES   = 16384;           // 16 KiB byte memory
	localparam int ADDR_W      = 14;              // Byte address width
	localparam int INSTR_BYTES = 4;               // PC step

	localparam logic [63:0] RESET_PC = 64'h2000;  // First fetch

	// ------------------------------------------------------------
	// FSM state codes
	localparam logic [2:0] S_FETCH     = 3'd0;
	localparam logic [2:0] S_DECODE    = 3'd1;
	localparam logic [2:0] S_EXECUTE   = 3'd2;
	localparam logic [2:0] S_MEMORY    = 3'd3;
	localparam logic [2:0] S_WRITEBACK = 3'd4;
	localparam logic [2:0] S_HALTED    = 3'd5;

endpackage

/* design/core_control.sv */
// Multicycle FSM with state register, next-state logic and per-state strobes
`timescale 1ns/1ns

module core_control (
	input  logic clk,
	input  logic reset,
	input  logic is_load,
	input  logic is_store,
	input  logic is_branch,
	input  logic is_halt,
	output logic ir_write,
	output logic exec_en,
	output logic mem_write,
	output logic mdr_load,
	output logic reg_write,
	output logic wb_from_mem,
	output logic pc_write,
	output logic hlt
);
	import core_pkg::*;

	logic [2:0] state, state_nxt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= S_FETCH;
		else
			state <= state_nxt;
	end

	// ------------------------------------------------------------
	always_comb begin
		case (state)
			S_FETCH:     state_nxt = S_DECODE;
			S_DECODE:    state_nxt = is_halt ? S_HALTED : S_EXECUTE;
			S_EXECUTE: begin
				if (is_load || is_store)
					state_nxt = S_MEMORY;
				else if (is_branch)
					state_nxt = S_FETCH;     // PC already written
				else
					state_nxt = S_WRITEBACK;
			end
			S_MEMORY:    state_nxt = S_WRITEBACK;
			S_WRITEBACK: state_nxt = S_FETCH;
			S_HALTED:    state_nxt = S_HALTED;  // Only reset leaves
			default:     state_nxt = S_FETCH;
		endcase
	end

	// Strobes, one cycle each
	assign ir_write    = (state == S_FETCH);
	assign exec_en     = (state == S_EXECUTE);
	assign mem_write   = (state == S_MEMORY) && is_store;
	assign mdr_load    = (state == S_MEMORY) && is_load;
	assign reg_write   = (state == S_WRITEBACK) && !is_store;
	assign wb_from_mem = (state == S_WRITEBACK) && is_load;
	assign pc_write    = ((state == S_EXECUTE) && is_branch) || (state == S_WRITEBACK);
	assign hlt         = (state == S_HALTED);

endmodule

/* design/instr_decode.sv */
// Instruction register, field extraction, immediate sign extension and class flags
`timescale 1ns/1ns

module instr_decode (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      ir_write,
	input  logic [isa_pkg::ILEN-1:0]  instr,
	output logic [isa_pkg::REG_W-1:0] rd,
	output logic [isa_pkg::REG_W-1:0] rs_sel,
	output logic [isa_pkg::REG_W-1:0] rt,
	output logic [isa_pkg::OP_W-1:0]  opcode,
	output logic [isa_pkg::XLEN-1:0]  imm,
	output logic                      use_imm,
	output logic                      is_load,
	output logic                      is_store,
	output logic                      is_branch,
	output logic                      is_halt
);
	import isa_pkg::*;

	logic [ILEN-1:0] ir;                          // Latched at end of FETCH

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			ir <= '0;
		else if (ir_write)
			ir <= instr;
	end

	assign opcode = ir[OP_LSB +: OP_W];
	assign rd     = ir[RD_LSB +: REG_W];
	assign rt     = ir[RT_LSB +: REG_W];
	assign imm    = {{(XLEN-IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};

	// Immediate ALU forms read rd as the first operand
	always_comb begin
		case (opcode)
			OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI: rs_sel = rd;
			default:                                rs_sel = ir[RS_LSB +: REG_W];
		endcase
	end

	assign use_imm   = opcode inside {OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI,
	                                  OP_MOVI, OP_LOAD, OP_STORE};
	assign is_load   = (opcode == OP_LOAD);
	assign is_store  = (opcode == OP_STORE);
	assign is_branch = opcode inside {OP_BR, OP_BRR, OP_BRRI, OP_BRNZ, OP_BRGT};
	assign is_halt   = (opcode == OP_HALT);

endmodule

/* design/reg_bank.sv */
// 32 x 64 register file with one write port and three combinational reads
`timescale 1ns/1ns

module reg_bank (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      we,
	input  logic [isa_pkg::REG_W-1:0] waddr,      // Also the rd read index
	input  logic [isa_pkg::REG_W-1:0] ra1,
	input  logic [isa_pkg::REG_W-1:0] ra2,
	input  logic [isa_pkg::XLEN-1:0]  wdata,
	output logic [isa_pkg::XLEN-1:0]  rd1,
	output logic [isa_pkg::XLEN-1:0]  rd2,
	output logic [isa_pkg::XLEN-1:0]  rd_dest
);
	import isa_pkg::*;

	logic [XLEN-1:0] regs [2**REG_W];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 2**REG_W; i++)
				regs[i] <= '0;
		end else if (we && (waddr != '0)) begin  // r0 stays zero
			regs[waddr] <= wdata;
		end
	end

	assign rd1     = regs[ra1];                   // rs
	assign rd2     = regs[ra2];                   // rt
	assign rd_dest = regs[waddr];                 // rd, branch target and store base

endmodule

/* design/exec_unit.sv */
// ALU with result register, branch target resolution and load/store address generation
`timescale 1ns/1ns

module exec_unit (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       exec_en,
	input  logic [isa_pkg::OP_W-1:0]   opcode,
	input  logic [isa_pkg::XLEN-1:0]   a,         // rs or rd value
	input  logic [isa_pkg::XLEN-1:0]   b,         // rt value
	input  logic [isa_pkg::XLEN-1:0]   d,         // rd value
	input  logic [isa_pkg::XLEN-1:0]   imm,
	input  logic [isa_pkg::XLEN-1:0]   pc,
	input  logic                       use_imm,
	output logic [isa_pkg::XLEN-1:0]   result,
	output logic [isa_pkg::XLEN-1:0]   next_pc,
	output logic [core_pkg::ADDR_W-1:0] data_addr,
	output logic [isa_pkg::XLEN-1:0]   store_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [XLEN-1:0] op_b, alu_out, pc_inc;

	assign op_b   = use_imm ? imm : b;           // Literal or rt
	assign pc_inc = pc + XLEN'(INSTR_BYTES);

	// ------------------------------------------------------------
	always_comb begin
		case (opcode)
			OP_AND:              alu_out = a & op_b;
			OP_OR:               alu_out = a | op_b;
			OP_XOR:              alu_out = a ^ op_b;
			OP_NOT:              alu_out = ~a;
			OP_SHFTR:            alu_out = a >> op_b;
			OP_SHFTRI:           alu_out = $signed(a) >>> op_b;  // Sign fill
			OP_SHFTL, OP_SHFTLI: alu_out = a << op_b;
			OP_ADD, OP_ADDI:     alu_out = a + op_b;
			OP_SUB, OP_SUBI:     alu_out = a - op_b;
			OP_MUL:              alu_out = a * op_b;
			OP_DIV:              alu_out = (op_b == '0) ? '0 : a / op_b;
			OP_MOV:              alu_out = a;
			OP_MOVI:             alu_out = op_b;
			default:             alu_out = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			result <= '0;
		else if (exec_en)
			result <= alu_out;
	end

	// Branch resolution with PC+4 when not taken
	always_comb begin
		case (opcode)
			OP_BR:   next_pc = d;
			OP_BRR:  next_pc = pc + d;
			OP_BRRI: next_pc = pc + imm;
			OP_BRNZ: next_pc = (a != '0) ? d : pc_inc;
			OP_BRGT: next_pc = ($signed(a) > $signed(b)) ? d : pc_inc;
			default: next_pc = pc_inc;
		endcase
	end

	// Load base is rs, store base is rd
	assign data_addr  = ADDR_W'(((opcode == OP_LOAD) ? a : d) + imm);
	assign store_data = a;

endmodule

/* design/result_stage.sv */
// PC register, memory data register and writeback source select
`timescale 1ns/1ns

module result_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     pc_write,
	input  logic                     mdr_load,
	input  logic                     wb_from_mem,
	input  logic [isa_pkg::XLEN-1:0] next_pc,
	input  logic [isa_pkg::XLEN-1:0] mem_rdata,
	input  logic [isa_pkg::XLEN-1:0] result,
	output logic [isa_pkg::XLEN-1:0] pc,
	output logic [isa_pkg::XLEN-1:0] wb_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [XLEN-1:0] mdr;                         // Load data

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= RESET_PC;
		else if (pc_write)
			pc <= next_pc;                        // Target or PC+4
	end

	always_ff @(posedge clk) begin
		if (mdr_load)
			mdr <= mem_rdata;
	end

	assign wb_data = wb_from_mem ? mdr : result;

endmodule

/* design/data_memory.sv */
// Little-endian byte memory with core fetch/data port and host load/read port
`timescale 1ns/1ns

module data_memory (
	input  logic                       clk,
	input  logic                       fetch,     // Address from PC
	input  logic [isa_pkg::XLEN-1:0]   pc,
	input  logic [core_pkg::ADDR_W-1:0] data_addr,
	input  logic                       we,
	input  logic [isa_pkg::XLEN-1:0]   wdata,
	output logic [isa_pkg::XLEN-1:0]   rdata,
	output logic [isa_pkg::ILEN-1:0]   instr,
	input  logic                       host_we,
	input  logic [core_pkg::ADDR_W-1:0] host_addr,
	input  logic [isa_pkg::XLEN-1:0]   host_wdata,
	output logic [isa_pkg::XLEN-1:0]   host_rdata
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [7:0]      mem [MEM_BYTES];
	logic [XLEN-1:0] base;
	logic [XLEN-1:0] core_a [8];                  // Byte addresses, core side
	logic [XLEN-1:0] host_a [8];                  // Byte addresses, host side

	assign base = fetch ? pc : XLEN'(data_addr);

	// ------------------------------------------------------------
	for (genvar k = 0; k < 8; k++) begin : g_byte
		assign core_a[k] = base + XLEN'(k);
		assign host_a[k] = XLEN'(host_addr) + XLEN'(k);
		// Past the end reads as zero
		assign rdata[8*k +: 8] = (core_a[k] < XLEN'(MEM_BYTES)) ?
		                         mem[core_a[k][ADDR_W-1:0]] : 8'h00;
		assign host_rdata[8*k +: 8] = (host_a[k] < XLEN'(MEM_BYTES)) ?
		                              mem[host_a[k][ADDR_W-1:0]] : 8'h00;
	end

	assign instr = rdata[ILEN-1:0];               // Low four bytes at PC

	always_ff @(posedge clk) begin
		for (int k = 0; k < 8; k++) begin
			if (we && (core_a[k] < XLEN'(MEM_BYTES)))
				mem[core_a[k][ADDR_W-1:0]] <= wdata[8*k +: 8];
			if (host_we && (host_a[k] < XLEN'(MEM_BYTES)))
				mem[host_a[k][ADDR_W-1:0]] <= host_wdata[8*k +: 8];
		end
	end

endmodule

/* design/tinker_top.sv */
// Top level of the multicycle core with control, datapath and memory instances
`timescale 1ns/1ns

module tinker_top (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       host_we,      // Host loads a word
	input  logic [core_pkg::ADDR_W-1:0] host_addr,
	input  logic [isa_pkg::XLEN-1:0]   host_wdata,
	output logic [isa_pkg::XLEN-1:0]   host_rdata,
	output logic                       hlt
);
	import isa_pkg::*;
	import core_pkg::*;

	// ------------------------------------------------------------
	// Control strobes and decode flags
	logic ir_write, exec_en, mem_write, mdr_load;
	logic reg_write, wb_from_mem, pc_write;
	logic is_load, is_store, is_branch, is_halt, use_imm;

	// Datapath
	logic [ILEN-1:0]   instr;                     // Word at PC
	logic [REG_W-1:0]  rd, rs_sel, rt;
	logic [OP_W-1:0]   opcode;
	logic [XLEN-1:0]   imm;
	logic [XLEN-1:0]   rd1, rd2, rd_dest;         // rs, rt, rd values
	logic [XLEN-1:0]   result, next_pc, pc, wb_data;
	logic [XLEN-1:0]   store_data, mem_rdata;
	logic [ADDR_W-1:0] data_addr;

	core_control u_core_control (
		.clk(clk), .reset(reset),
		.is_load(is_load), .is_store(is_store), .is_branch(is_branch), .is_halt(is_halt),
		.ir_write(ir_write), .exec_en(exec_en), .mem_write(mem_write), .mdr_load(mdr_load),
		.reg_write(reg_write), .wb_from_mem(wb_from_mem), .pc_write(pc_write), .hlt(hlt)
	);

	instr_decode u_instr_decode (
		.clk(clk), .reset(reset), .ir_write(ir_write), .instr(instr),
		.rd(rd), .rs_sel(rs_sel), .rt(rt), .opcode(opcode), .imm(imm), .use_imm(use_imm),
		.is_load(is_load), .is_store(is_store), .is_branch(is_branch), .is_halt(is_halt)
	);

	reg_bank u_reg_bank (
		.clk(clk), .reset(reset), .we(reg_write), .waddr(rd), .ra1(rs_sel), .ra2(rt),
		.wdata(wb_data), .rd1(rd1), .rd2(rd2), .rd_dest(rd_dest)
	);

	exec_unit u_exec_unit (
		.clk(clk), .reset(reset), .exec_en(exec_en), .opcode(opcode),
		.a(rd1), .b(rd2), .d(rd_dest), .imm(imm), .pc(pc), .use_imm(use_imm),
		.result(result), .next_pc(next_pc), .data_addr(data_addr), .store_data(store_data)
	);

	result_stage u_result_stage (
		.clk(clk), .reset(reset), .pc_write(pc_write), .mdr_load(mdr_load),
		.wb_from_mem(wb_from_mem), .next_pc(next_pc), .mem_rdata(mem_rdata),
		.result(result), .pc(pc), .wb_data(wb_data)
	);

	data_memory u_data_memory (
		.clk(clk), .fetch(ir_write), .pc(pc), .data_addr(data_addr),
		.we(mem_write), .wdata(store_data), .rdata(mem_rdata), .instr(instr),
		.host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
		.host_rdata(host_rdata)
	);

endmodule

/* testbench/tb_tinker.sv */
// Self-checking testbench for tinker_top, with a host-loaded program and memory checks
`timescale 1ns/1ns

module tb_tinker;
	import isa_pkg::*;
	import core_pkg::*;

	logic              clk;
	logic              reset;
	logic              host_we;
	logic [ADDR_W-1:0] host_addr;
	logic [XLEN-1:0]   host_wdata;
	logic [XLEN-1:0]   host_rdata;
	logic              hlt;

	// Contents of the data file
	logic [ADDR_W-1:0] load_addr [$];              // L lines
	logic [XLEN-1:0]   load_data [$];
	logic [ADDR_W-1:0] chk_addr [$];               // C lines
	logic [XLEN-1:0]   chk_data [$];
	int                halt_limit;                 // T line, in cycles
	int                cyc;

	tinker_top u_tinker_top (
		.clk(clk), .reset(reset), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_rdata(host_rdata), .hlt(hlt)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;                          // 4 ns period

	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [XLEN-1:0] exp,
	                           input logic [XLEN-1:0] got);
		if (got !== exp) begin
			$display("[FAIL] %s exp %h got %h", name, exp, got);
			$display("Regression failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic load_stimulus_file();
		int          fd;
		int          n;
		string       line;
		byte         kind;
		logic [63:0] f1, f2;
		fd = $fopen("testbench/tinker_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/tinker_input.txt for reading");
			$display("Regression failed");
			$fatal(1, "Missing data file");
		end
		halt_limit = 1000;                         // Used if no T line
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%c %h %h", kind, f1, f2);
			if (n >= 2) begin
				case (kind)
					"L": begin
						load_addr.push_back(f1[ADDR_W-1:0]);
						load_data.push_back(f2);
					end
					"C": begin
						chk_addr.push_back(f1[ADDR_W-1:0]);
						chk_data.push_back(f2);
					end
					"T":     halt_limit = int'(f1);
					default: ;                     // Comment lines
				endcase
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------
	initial begin
		reset      = 1'b1;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		load_stimulus_file();

		// Reset for at least 5 cycles, longer while host loads remain
		cyc = 0;
		while (cyc < 5 || cyc <= load_addr.size()) begin
			@(posedge clk);
			if (cyc < load_addr.size()) begin
				host_we    <= 1'b1;
				host_addr  <= load_addr[cyc];
				host_wdata <= load_data[cyc];
			end else begin
				host_we <= 1'b0;                   // Last word lands here
			end
			@(negedge clk);
			check_value("hlt", '0, 64'(hlt));      // Low during reset
			cyc++;
		end
		@(posedge clk);
		reset <= 1'b0;

		// Run until halt
		cyc = 0;
		@(negedge clk);
		while (hlt !== 1'b1) begin
			if (cyc >= halt_limit) begin
				$display("Timeout: hlt never rose within %0d cycles", halt_limit);
				$display("Regression failed");
				$fatal(1, "Halt timeout");
			end
			@(negedge clk);
			cyc++;
		end
		repeat (20) begin                          // hlt must hold
			@(negedge clk);
			check_value("hlt", 64'(1), 64'(hlt));
		end

		// Read back expected words over the host port
		foreach (chk_addr[i]) begin
			@(posedge clk);
			host_addr <= chk_addr[i];
			@(negedge clk);
			check_value($sformatf("mem[%h]", chk_addr[i]), chk_data[i], host_rdata);
		end

		$display("Regression passed");
		$finish;
	end

endmodule

/* testbench/tinker_input.txt */
# L addr data = host load of one 64-bit word, T cycles = halt timeout
# C addr value = expected word after halt, every field in hex
T 800
L 0180 0000000000000000
L 0188 0000000000000000
L 0200 0123456789ABCDEF
L 0300 A5A55A5A0F0FF0F0
# Program at 2000, two instructions per word, low word first
L 2000 90C0003590800FFA
L 2008 9808010001043000
L 2010 9808010809043000
L 2018 9808011011043000
L 2020 9808011819060000
L 2028 9808012021043000
L 2030 9808012831063000
L 2038 98080130C1043000
L 2040 98080138D1062000
L 2048 98080140E1043000
L 2050 E906800092000005
L 2058 E906000098080148
L 2060 8986000098080150
L 2068 980C0158C9800010
L 2070 980C0160D9800050
L 2078 980C016829800002
L 2080 980C017039800004
L 2088 980E018381C00200
L 2090 8152000392400180
L 2098 90000123980A0190
L 20A0 92C0020098000198
L 20A8 930000D03AC00004
L 20B0 938000FCC318B000
L 20B8 93C00110C39CB000
L 20C0 93400008C3DEB000
L 20C8 C840040043000000
L 20D0 4B400000C8400001
L 20D8 C8400002C8400400
L 20E0 C840040050000008
L 20E8 50000004C8400004
L 20F0 5B840000C8400008
L 20F8 C8400010C8400400
L 2100 C840002058000000
L 2108 C840040073C62000
L 2110 70043000C8400040
L 2118 980201A0C8400080
L 2120 00000000F8000000
# ALU results in register and immediate form
C 0100 0000000000000030
C 0108 FFFFFFFFFFFFFFFF
C 0110 FFFFFFFFFFFFFFCF
C 0118 FFFFFFFFFFFFFFCA
C 0120 00000000000007FF
C 0128 06A0000000000000
C 0130 000000000000002F
C 0138 000000000000003B
C 0140 FFFFFFFFFFFFFEC2
C 0148 000000000000000A
C 0150 0000000000000000
C 0158 0000000000000045
C 0160 FFFFFFFFFFFFFFF5
C 0168 FFFFFFFFFFFFFFFD
C 0170 FFFFFFFFFFFFFFD0
# Unaligned store and load, r0 store, branch markers, untouched words
C 0180 6789ABCDEF000000
C 0188 0000000000012345
C 0190 0123456789ABCDEF
C 0198 0000000000000000
C 01A0 00000000000000FF
C 0200 0123456789ABCDEF
C 0300 A5A55A5A0F0FF0F0
C 2120 00000000F8000000

/* files.f */
design/isa_pkg.sv
design/core_pkg.sv
design/core_control.sv
design/instr_decode.sv
design/reg_bank.sv
design/exec_unit.sv
design/result_stage.sv
design/data_memory.sv
design/tinker_top.sv
testbench/tb_tinker.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_tinker
RTL_TOP   = tinker_top
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
